// ==== mips_cp0.f ====
src/cp0_pkg.sv
src/exc_ctrl.sv
src/cp0_regs.sv
src/cp0_top.sv
testbench/tb_cp0.sv

// ==== Bender.yml ====
package:
  name: mips_cp0

dependencies: {}

sources:
  - src/cp0_pkg.sv
  - src/exc_ctrl.sv
  - src/cp0_regs.sv
  - src/cp0_top.sv
  - target: test
    files:
      - testbench/tb_cp0.sv

// ==== testbench/tb_cp0.sv ====
`timescale 1ns/1ps

module tb_cp0;
    import cp0_pkg::*;

    localparam int HALF_PERIOD = 20;
    // About four times the length of all tests
    localparam int WATCHDOG_CYCLES = 400;
    localparam logic [31:0] TIMER_CMP = 32'h0000_0200;

    logic        clk;
    logic        rst;
    logic [5:0]  int_i;
    mem_exc_t    mem_i;
    cp0_wr_t     wr_i;
    logic [4:0]  raddr_i;
    logic [31:0] rdata_o;
    logic        flush_o;
    logic [31:0] new_pc_o;
    logic        timer_int_o;

    int     errors = 0;
    int     failures = 0;
    integer seed;

    cp0_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .int_i       (int_i),
        .mem_i       (mem_i),
        .wr_i        (wr_i),
        .raddr_i     (raddr_i),
        .rdata_o     (rdata_o),
        .flush_o     (flush_o),
        .new_pc_o    (new_pc_o),
        .timer_int_o (timer_int_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wr_i.we   = 1'b1;
        wr_i.addr = addr;
        wr_i.data = data;
        @(negedge clk);
        wr_i = '0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge clk);
        raddr_i = addr;
        #1;
        data = rdata_o;
    endtask

    // One memory-stage slot for a cycle and its same-cycle answer
    task automatic drive_instr(input mem_exc_t m, input logic exp_flush,
                               input logic [31:0] exp_pc);
        @(negedge clk);
        mem_i = m;
        #1;
        check("flush_o", flush_o, exp_flush);
        if (exp_flush) begin
            check("new_pc_o", new_pc_o, exp_pc);
        end
        @(negedge clk);
        mem_i = '0;
    endtask

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    task automatic reset_values();
        logic [31:0] rd;
        read_reg(CP0_STATUS, rd);
        check("status", rd, STATUS_RESET);
        read_reg(CP0_CAUSE, rd);
        check("cause", rd, 32'h0);
        read_reg(CP0_EPC, rd);
        check("epc", rd, 32'h0);
        read_reg(CP0_PRID, rd);
        check("prid", rd, PRID_VALUE);
        read_reg(CP0_CONFIG, rd);
        check("config", rd, CONFIG_VALUE);
        check("flush_o", flush_o, 1'b0);
        check("timer_int_o", timer_int_o, 1'b0);
    endtask

    task automatic masked_writes();
        logic [31:0] rd;
        logic [31:0] epc_val;
        logic [31:0] status_exp;
        logic [31:0] cause_exp;
        epc_val    = $random(seed);
        status_exp = STATUS_RESET | (32'hFF << ST_IM_LO) | (32'h1 << ST_EXL) | (32'h1 << ST_IE);
        cause_exp  = (32'h3 << CA_IP_LO) | (32'h1 << CA_IV) | (32'h1 << CA_WP)
                   | (32'h05 << (CA_IP_LO + 2));
        @(negedge clk);
        int_i = 6'h05;
        write_reg(CP0_STATUS, '1);
        write_reg(CP0_CAUSE, '1);
        write_reg(CP0_PRID, '1);
        write_reg(CP0_EPC, epc_val);
        read_reg(CP0_STATUS, rd);
        check("status masked", rd, status_exp);
        read_reg(CP0_CAUSE, rd);
        check("cause masked", rd, cause_exp);
        read_reg(CP0_PRID, rd);
        check("prid read-only", rd, PRID_VALUE);
        read_reg(CP0_EPC, rd);
        check("epc", rd, epc_val);
        // Back to a quiet state
        @(negedge clk);
        int_i = '0;
        write_reg(CP0_CAUSE, '0);
        write_reg(CP0_STATUS, '0);
    endtask

    task automatic timer_match();
        logic [31:0] rd;
        int          polls;
        write_reg(CP0_COMPARE, TIMER_CMP);
        write_reg(CP0_COUNT, TIMER_CMP - 32'd5);
        polls = 0;
        while (!timer_int_o && polls < 20) begin
            read_reg(CP0_COUNT, rd);
            polls++;
        end
        if (!timer_int_o) begin
            failures++;
            $display("Timer interrupt did not rise within 20 cycles of the Count write");
        end
        read_reg(CP0_COUNT, rd);
        check("count past compare", rd > TIMER_CMP, 1'b1);
        // IP7 follows one cycle later
        read_reg(CP0_CAUSE, rd);
        check("cause.ip7", rd[CA_IP_HI], 1'b1);
        write_reg(CP0_COMPARE, '0);
        check("timer_int_o after compare write", timer_int_o, 1'b0);
    endtask

    task automatic sync_exceptions();
        mem_exc_t    m;
        logic [31:0] rd;
        logic [31:0] pc1;
        pc1 = rand_pc();
        m = '0;
        m.pc = pc1;
        m.valid = 1'b1;
        m.in_delayslot = 1'b1;
        m.syscall = 1'b1;
        drive_instr(m, 1'b1, EXC_VECTOR);
        read_reg(CP0_CAUSE, rd);
        check("cause.exccode", rd[CA_EXC_HI:CA_EXC_LO], EXC_SYS);
        check("cause.bd", rd[CA_BD], 1'b1);
        read_reg(CP0_EPC, rd);
        check("epc", rd, pc1 - 32'd4);
        read_reg(CP0_STATUS, rd);
        check("status.exl", rd[ST_EXL], 1'b1);
        // Nested exception keeps the first EPC
        m = '0;
        m.pc = rand_pc();
        m.valid = 1'b1;
        m.ri = 1'b1;
        drive_instr(m, 1'b1, EXC_VECTOR);
        read_reg(CP0_CAUSE, rd);
        check("cause.exccode", rd[CA_EXC_HI:CA_EXC_LO], EXC_RI);
        read_reg(CP0_EPC, rd);
        check("epc kept", rd, pc1 - 32'd4);
        m.valid = 1'b0;
        m.syscall = 1'b1;
        drive_instr(m, 1'b0, 32'h0);
    endtask

    task automatic priority_and_eret();
        mem_exc_t    m;
        logic [31:0] rd;
        logic [31:0] pc3;
        write_reg(CP0_STATUS, '0);
        pc3 = rand_pc();
        m = '0;
        m.pc = pc3;
        m.valid = 1'b1;
        m.ov = 1'b1;
        m.trap = 1'b1;
        drive_instr(m, 1'b1, EXC_VECTOR);
        read_reg(CP0_CAUSE, rd);
        check("cause.exccode", rd[CA_EXC_HI:CA_EXC_LO], EXC_OV);
        check("cause.bd", rd[CA_BD], 1'b0);
        read_reg(CP0_EPC, rd);
        check("epc", rd, pc3);
        m = '0;
        m.pc = rand_pc();
        m.valid = 1'b1;
        m.ri = 1'b1;
        m.ov = 1'b1;
        drive_instr(m, 1'b1, EXC_VECTOR);
        read_reg(CP0_CAUSE, rd);
        check("cause.exccode", rd[CA_EXC_HI:CA_EXC_LO], EXC_RI);
        m = '0;
        m.pc = rand_pc();
        m.valid = 1'b1;
        m.eret = 1'b1;
        drive_instr(m, 1'b1, pc3);
        read_reg(CP0_STATUS, rd);
        check("status.exl after eret", rd[ST_EXL], 1'b0);
    endtask

    task automatic interrupt_entry();
        mem_exc_t    m;
        logic [31:0] rd;
        logic [31:0] im4;
        logic [31:0] quiet [3];
        im4 = 32'h1 << (ST_IM_LO + 4);
        quiet[0] = im4;
        quiet[1] = 32'h1 << ST_IE;
        quiet[2] = im4 | (32'h1 << ST_IE) | (32'h1 << ST_EXL);
        @(negedge clk);
        int_i = 6'b000100;
        write_reg(CP0_STATUS, im4 | (32'h1 << ST_IE));
        m = '0;
        m.pc = rand_pc();
        m.valid = 1'b1;
        drive_instr(m, 1'b1, EXC_VECTOR);
        read_reg(CP0_CAUSE, rd);
        check("cause.exccode", rd[CA_EXC_HI:CA_EXC_LO], EXC_INT);
        read_reg(CP0_EPC, rd);
        check("epc", rd, m.pc);
        // Each of IE clear, IM clear and EXL set masks the line
        for (int i = 0; i < 3; i++) begin
            write_reg(CP0_STATUS, quiet[i]);
            drive_instr(m, 1'b0, 32'h0);
        end
        @(negedge clk);
        int_i = '0;
    endtask

    initial begin
        seed    = 32'h70b1cca5;
        rst     = 1'b1;
        int_i   = '0;
        mem_i   = '0;
        wr_i    = '0;
        raddr_i = CP0_STATUS;
        repeat (2) @(negedge clk);
        #1;
        check("rdata_o in reset", rdata_o, 32'h0);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        masked_writes();
        timer_match();
        sync_exceptions();
        priority_and_eret();
        interrupt_entry();
        $display("Summary: %0d value mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== src/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [5:0]        int_i,
    input  cp0_pkg::mem_exc_t mem_i,
    input  cp0_pkg::cp0_wr_t  wr_i,
    input  logic [4:0]        raddr_i,
    output logic [31:0]       rdata_o,
    output logic              flush_o,
    output logic [31:0]       new_pc_o,
    output logic              timer_int_o
);
    import cp0_pkg::*;

    exc_kind_e  kind;
    cp0_state_t state;

    exc_ctrl exc0 (
        .mem_i    (mem_i),
        .state_i  (state),
        .kind_o   (kind),
        .flush_o  (flush_o),
        .new_pc_o (new_pc_o)
    );

    // Register file sees the same request the controller ranked
    cp0_regs regs0 (
        .clk         (clk),
        .rst         (rst),
        .int_i       (int_i),
        .wr_i        (wr_i),
        .raddr_i     (raddr_i),
        .mem_i       (mem_i),
        .kind_i      (kind),
        .rdata_o     (rdata_o),
        .state_o     (state),
        .timer_int_o (timer_int_o)
    );

endmodule

// ==== src/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic [5:0]          int_i,
    input  cp0_pkg::cp0_wr_t    wr_i,
    input  logic [4:0]          raddr_i,
    input  cp0_pkg::mem_exc_t   mem_i,
    input  cp0_pkg::exc_kind_e  kind_i,
    output logic [31:0]         rdata_o,
    output cp0_pkg::cp0_state_t state_o,
    output logic                timer_int_o
);
    import cp0_pkg::*;

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;

    logic        take_exc;
    logic        save_epc;
    logic [31:0] victim_pc;
    logic        timer_hit;

    function automatic logic [4:0] exc_code(input exc_kind_e kind);
        case (kind)
            EK_ADEL: exc_code = EXC_ADEL;
            EK_ADES: exc_code = EXC_ADES;
            EK_SYS:  exc_code = EXC_SYS;
            EK_BP:   exc_code = EXC_BP;
            EK_RI:   exc_code = EXC_RI;
            EK_OV:   exc_code = EXC_OV;
            EK_TR:   exc_code = EXC_TR;
            default: exc_code = EXC_INT;
        endcase
    endfunction

    // Everything but none and eret enters the handler
    assign take_exc = (kind_i != EK_NONE) && (kind_i != EK_ERET);

    // Nested exceptions keep the first EPC
    assign save_epc = take_exc && (!status_q[ST_EXL] || kind_i == EK_INT);

    // Delay slot restarts at the branch
    assign victim_pc = mem_i.in_delayslot ? mem_i.pc - 32'd4 : mem_i.pc;

    assign timer_hit = (compare_q != '0) && (count_q == compare_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            compare_q   <= '0;
            status_q    <= STATUS_RESET;
            cause_q     <= '0;
            epc_q       <= '0;
            timer_int_o <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;

            // Hardware lines with the timer ORed into IP7
            cause_q[CA_IP_HI:CA_IP_LO+2] <= {int_i[5] | timer_int_o, int_i[4:0]};

            if (timer_hit) begin
                timer_int_o <= 1'b1;
            end

            if (wr_i.we) begin
                case (wr_i.addr)
                    CP0_COUNT: begin
                        count_q <= wr_i.data;
                    end
                    CP0_COMPARE: begin
                        compare_q   <= wr_i.data;
                        timer_int_o <= 1'b0;
                    end
                    CP0_STATUS: begin
                        status_q[ST_IM_HI:ST_IM_LO] <= wr_i.data[ST_IM_HI:ST_IM_LO];
                        status_q[ST_EXL]            <= wr_i.data[ST_EXL];
                        status_q[ST_IE]             <= wr_i.data[ST_IE];
                    end
                    CP0_CAUSE: begin
                        // Software interrupt bits IP1..IP0
                        cause_q[CA_IP_LO+1:CA_IP_LO] <= wr_i.data[CA_IP_LO+1:CA_IP_LO];
                        cause_q[CA_IV]               <= wr_i.data[CA_IV];
                        cause_q[CA_WP]               <= wr_i.data[CA_WP];
                    end
                    CP0_EPC: begin
                        epc_q <= wr_i.data;
                    end
                    default: begin
                    end
                endcase
            end

            // Exception updates come last so they override mtc0
            if (take_exc) begin
                status_q[ST_EXL]             <= 1'b1;
                cause_q[CA_EXC_HI:CA_EXC_LO] <= exc_code(kind_i);
                if (save_epc) begin
                    epc_q          <= victim_pc;
                    cause_q[CA_BD] <= mem_i.in_delayslot;
                end
            end else if (kind_i == EK_ERET) begin
                status_q[ST_EXL] <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (!rst) begin
            case (raddr_i)
                CP0_COUNT: begin
                    rdata_o = count_q;
                end
                CP0_COMPARE: begin
                    rdata_o = compare_q;
                end
                CP0_STATUS: begin
                    rdata_o = status_q;
                end
                CP0_CAUSE: begin
                    rdata_o = cause_q;
                end
                CP0_EPC: begin
                    rdata_o = epc_q;
                end
                CP0_PRID: begin
                    rdata_o = PRID_VALUE;
                end
                CP0_CONFIG: begin
                    rdata_o = CONFIG_VALUE;
                end
                default: begin
                    rdata_o = '0;
                end
            endcase
        end
    end

    // State seen by the exception controller
    assign state_o.status   = status_q;
    assign state_o.cause_ip = cause_q[CA_IP_HI:CA_IP_LO];
    assign state_o.epc      = epc_q;

endmodule

// ==== src/exc_ctrl.sv ====
`timescale 1ns/1ps

module exc_ctrl (
    input  cp0_pkg::mem_exc_t   mem_i,
    input  cp0_pkg::cp0_state_t state_i,
    output cp0_pkg::exc_kind_e  kind_o,
    output logic                flush_o,
    output logic [31:0]         new_pc_o
);
    import cp0_pkg::*;

    logic       int_enabled;
    logic [7:0] int_masked;
    logic       int_pending;

    // Interrupts only outside the handler
    assign int_enabled = state_i.status[ST_IE] && !state_i.status[ST_EXL];

    assign int_masked = state_i.cause_ip & state_i.status[ST_IM_HI:ST_IM_LO];

    // Needs a real instruction to attach the EPC to
    assign int_pending = int_enabled && (|int_masked) && mem_i.valid;

    always_comb begin
        kind_o = EK_NONE;
        if (mem_i.valid) begin
            // Highest priority first
            if (int_pending) begin
                kind_o = EK_INT;
            end else if (mem_i.adel) begin
                kind_o = EK_ADEL;
            end else if (mem_i.ri) begin
                kind_o = EK_RI;
            end else if (mem_i.ov) begin
                kind_o = EK_OV;
            end else if (mem_i.trap) begin
                kind_o = EK_TR;
            end else if (mem_i.syscall) begin
                kind_o = EK_SYS;
            end else if (mem_i.brk) begin
                kind_o = EK_BP;
            end else if (mem_i.ades) begin
                kind_o = EK_ADES;
            end else if (mem_i.eret) begin
                kind_o = EK_ERET;
            end
        end
    end

    assign flush_o = (kind_o != EK_NONE);

    // Eret returns to EPC, everything else to the general vector
    always_comb begin
        if (kind_o == EK_ERET) begin
            new_pc_o = state_i.epc;
        end else begin
            new_pc_o = EXC_VECTOR;
        end
    end

endmodule

// ==== src/cp0_pkg.sv ====
package cp0_pkg;

    // CP0 register numbers
    localparam logic [4:0] CP0_COUNT   = 5'd9;
    localparam logic [4:0] CP0_COMPARE = 5'd11;
    localparam logic [4:0] CP0_STATUS  = 5'd12;
    localparam logic [4:0] CP0_CAUSE   = 5'd13;
    localparam logic [4:0] CP0_EPC     = 5'd14;
    localparam logic [4:0] CP0_PRID    = 5'd15;
    localparam logic [4:0] CP0_CONFIG  = 5'd16;

    // Status fields
    localparam int ST_IE    = 0;
    localparam int ST_EXL   = 1;
    localparam int ST_IM_LO = 8;
    localparam int ST_IM_HI = 15;
    localparam int ST_BEV   = 22;

    // Cause fields
    localparam int CA_EXC_LO = 2;
    localparam int CA_EXC_HI = 6;
    localparam int CA_IP_LO  = 8;
    localparam int CA_IP_HI  = 15;
    localparam int CA_WP     = 22;
    localparam int CA_IV     = 23;
    localparam int CA_BD     = 31;

    // ExcCode values
    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;
    localparam logic [4:0] EXC_TR   = 5'd13;

    localparam logic [31:0] STATUS_RESET = 32'd1 << ST_BEV;
    localparam logic [31:0] PRID_VALUE   = 32'h0000_4220;
    // K0 cacheable, little endian
    localparam logic [31:0] CONFIG_VALUE = 32'h0000_0003;
    localparam logic [31:0] EXC_VECTOR   = 32'hBFC0_0380;

    typedef enum logic [3:0] {
        EK_NONE, EK_INT, EK_ADEL, EK_ADES, EK_SYS,
        EK_BP, EK_RI, EK_OV, EK_TR, EK_ERET
    } exc_kind_e;

    typedef struct packed {
        logic [31:0] pc;
        logic        in_delayslot;
        logic        valid;
        logic        adel;
        logic        ades;
        logic        syscall;
        logic        brk;
        logic        ri;
        logic        ov;
        logic        trap;
        logic        eret;
    } mem_exc_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    typedef struct packed {
        logic [31:0] status;
        logic [7:0]  cause_ip;
        logic [31:0] epc;
    } cp0_state_t;

endpackage
